//--- all.f
+incdir+hw
hw/ines_pkg.sv
hw/cheat_pkg.sv
hw/ines_header_if.sv
hw/ines_header_decoder.sv
hw/rom_stream_loader.sv
hw/cheat_code_packer.sv
hw/nes_download_top.sv
tb/tb_nes_download.sv

//--- Bender.yml
package:
  name: nes_download

sources:
  - include_dirs:
      - hw
    files:
      - hw/ines_pkg.sv
      - hw/cheat_pkg.sv
      - hw/ines_header_if.sv
      - hw/ines_header_decoder.sv
      - hw/rom_stream_loader.sv
      - hw/cheat_code_packer.sv
      - hw/nes_download_top.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/tb_nes_download.sv

//--- tb/tb_nes_download.sv
// Testbench for the cartridge download top level
// Table of ROM and cheat files, reference model for flags and codes, compare tasks

`timescale 1ns/1ps
`include "nes_loader_consts.svh"

module tb_nes_download;

	typedef struct packed {
		logic [7:0]              ftype;
		logic                    inv;
		logic [127:0]            bytes;       // Byte 0 in the top slot
		logic                    exp_err;
		logic [7:0]              exp_prg;
		logic [7:0]              exp_chr;
		ines_pkg::mapper_flags_t exp_flags;
		cheat_pkg::cheat_code_t  exp_code;
	} row_t;

	localparam int NUM_ROWS = 6;

	logic                    clk = 1'b0;
	logic                    reset_nes;
	logic                    downloading;
	logic [7:0]              file_type;
	logic                    in_strobe;
	logic [7:0]              in_data;
	logic                    invert_mirroring;
	logic [`MEM_ADDR_W-1:0]  mem_addr;
	logic [7:0]              mem_data;
	logic                    mem_write;
	logic                    busy;
	logic                    done;
	logic                    error;
	ines_pkg::mapper_flags_t mapper_flags;
	cheat_pkg::cheat_code_t  cheat_code;
	logic                    cheat_valid;

	row_t rows [NUM_ROWS];
	row_t last_rom;
	int   write_count = 0;
	int   valid_count = 0;

	nes_download_top dut_i (.*);

	always #5 clk = ~clk;

	// Pulse counters, sampled mid cycle
	always @(negedge clk) begin
		if (mem_write)
			write_count++;
		if (cheat_valid)
			valid_count++;
	end

	//////////////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] hdr_byte(input logic [127:0] bytes, input int k);
		return bytes[127 - 8*k -: 8];
	endfunction

	function automatic logic [2:0] page_class(input logic [7:0] pages);
		int n;
		n = 0;
		while (n < 7 && (32'd1 << n) < pages)
			n++;
		return n[2:0];
	endfunction

	function automatic ines_pkg::mapper_flags_t model_flags(input logic [127:0] bytes,
	                                                        input logic inv);
		ines_pkg::mapper_flags_t f;
		logic [7:0]              b6;
		logic [7:0]              b7;
		logic                    nes2;
		logic                    dirty;
		b6    = hdr_byte(bytes, 6);
		b7    = hdr_byte(bytes, 7);
		nes2  = (b7 & 8'h0C) == 8'h08;
		dirty = !nes2 && (hdr_byte(bytes, 9) > 8'd1 || bytes[47:0] != 48'd0);   // Bytes 10..15
		f             = '0;
		f.mapper      = {dirty ? 4'h0 : b7[7:4], b6[7:4]};
		f.prg_size    = page_class(hdr_byte(bytes, 4));
		f.chr_size    = page_class(hdr_byte(bytes, 5));
		f.has_chr_ram = hdr_byte(bytes, 5) == 8'd0;
		f.mirroring   = b6[0] ^ inv;
		f.four_screen = b6[3];
		f.has_saves   = b6[1];
		if (nes2) begin
			f.submapper_byte = hdr_byte(bytes, 8);
			f.prg_ram_shift  = 4'(hdr_byte(bytes, 10));
			f.piano          = (hdr_byte(bytes, 15) & 8'h3F) == 8'h19;
		end
		return f;
	endfunction

	function automatic logic model_error(input logic [127:0] bytes);
		logic [7:0] b6;
		b6 = hdr_byte(bytes, 6);
		return (bytes[127:96] != {`INES_MAGIC0, `INES_MAGIC1, `INES_MAGIC2, `INES_MAGIC3}) ||
		       b6[2];
	endfunction

	// Four bytes per field, lowest byte first
	function automatic cheat_pkg::cheat_code_t model_code(input logic [127:0] bytes);
		cheat_pkg::cheat_code_t c;
		logic [31:0]            word;
		for (int f = 0; f < 4; f++) begin
			for (int k = 0; k < 4; k++)
				word[8*k +: 8] = hdr_byte(bytes, 4*f + k);
			case (f)
			0: c.flags   = word;
			1: c.address = word;
			2: c.compare = word;
			default: c.replace = word;
			endcase
		end
		return c;
	endfunction

	task automatic add_row(input int idx, input logic [7:0] ftype, input logic inv,
	                       input logic [127:0] bytes);
		row_t r;
		r.ftype     = ftype;
		r.inv       = inv;
		r.bytes     = bytes;
		r.exp_err   = model_error(bytes);
		r.exp_prg   = hdr_byte(bytes, 4);
		r.exp_chr   = hdr_byte(bytes, 5);
		r.exp_flags = model_flags(bytes, inv);
		r.exp_code  = model_code(bytes);
		rows[idx]   = r;
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////////////

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_with($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flags(input ines_pkg::mapper_flags_t got,
	                           input ines_pkg::mapper_flags_t exp);
		if (got !== exp)
			fail_with($sformatf("ERROR mapper_flags got %h expected %h", got, exp));
	endtask

	task automatic check_code(input cheat_pkg::cheat_code_t got,
	                          input cheat_pkg::cheat_code_t exp);
		if (got !== exp)
			fail_with($sformatf("ERROR cheat_code got %h expected %h", got, exp));
	endtask

	task automatic check_write(input logic [`MEM_ADDR_W-1:0] addr, input logic [7:0] data);
		if (mem_addr !== addr)
			fail_with($sformatf("ERROR mem_addr got %h expected %h", mem_addr, addr));
		if (mem_data !== data)
			fail_with($sformatf("ERROR mem_data got %h expected %h", mem_data, data));
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Host side drivers
	//////////////////////////////////////////////////////////////////////////////

	task automatic gap();
		repeat (2) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One strobe cycle, write outputs checked mid cycle
	task automatic send_byte(input logic [7:0] data, input logic expect_wr,
	                         input logic [`MEM_ADDR_W-1:0] addr);
		in_data   = data;
		in_strobe = 1'b1;
		@(negedge clk);
		check_bit("mem_write", mem_write, expect_wr);
		if (expect_wr)
			check_write(addr, data);
		@(posedge clk);
		#1 in_strobe = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (done !== 1'b1) begin
			if (cycles == 100)
				fail_with("Timed out waiting for done after the last byte");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic run_rom_row(input row_t r);
		int n_prg;
		int n_chr;
		int wbase;
		n_prg = int'(r.exp_prg) << `PRG_PAGE_SHIFT;
		n_chr = int'(r.exp_chr) << `CHR_PAGE_SHIFT;
		wbase = write_count;
		file_type        = r.ftype;
		invert_mirroring = r.inv;
		downloading      = 1'b1;
		gap();
		for (int k = 0; k < `INES_HEADER_BYTES; k++) begin
			if (k != 0)
				gap();
			send_byte(hdr_byte(r.bytes, k), 1'b0, '0);   // Header never reaches memory
		end
		@(negedge clk);
		check_bit("busy", busy, 1'b1);
		@(posedge clk);
		#1;
		@(posedge clk);
		#1;
		if (!r.exp_err) begin
			for (int i = 0; i < n_prg; i++) begin
				send_byte(8'($urandom()), 1'b1, `MEM_ADDR_W'(i));
				gap();
			end
			for (int i = 0; i < n_chr; i++) begin
				send_byte(8'($urandom()), 1'b1, `CHR_BASE_ADDR + `MEM_ADDR_W'(i));
				gap();
			end
		end
		wait_done();
		check_bit("error", error, r.exp_err);
		check_bit("busy", busy, 1'b0);
		if (!r.exp_err)
			check_flags(mapper_flags, r.exp_flags);
		if (write_count != wbase + (r.exp_err ? 0 : n_prg + n_chr))
			fail_with("Wrong number of memory writes for the ROM image");
		downloading = 1'b0;
		gap();
	endtask

	// ROM status expected from the image loaded before the cheat file
	task automatic run_cheat_row(input row_t r, input row_t rom);
		int wbase;
		int vbase;
		int cycles;
		wbase       = write_count;
		vbase       = valid_count;
		file_type   = r.ftype;
		downloading = 1'b1;
		gap();
		for (int k = 0; k < 16; k++) begin
			if (k != 0)
				gap();
			send_byte(hdr_byte(r.bytes, k), 1'b0, '0);
		end
		cycles = 0;
		while (cheat_valid !== 1'b1) begin
			if (cycles == 20)
				fail_with("Timed out waiting for cheat_valid");
			@(negedge clk);
			cycles++;
		end
		check_code(cheat_code, r.exp_code);
		gap();
		gap();
		if (valid_count != vbase + 1)
			fail_with("cheat_valid did not pulse exactly once");
		if (write_count != wbase)
			fail_with("Memory write seen during the cheat download");
		check_bit("done", done, 1'b1);     // ROM status left alone
		check_bit("error", error, rom.exp_err);
		check_flags(mapper_flags, rom.exp_flags);
		downloading = 1'b0;
		gap();
	endtask

	//////////////////////////////////////////////////////////////////////////////
	// Stimulus table and run
	//////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hb301));
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		file_type        = 8'h00;
		in_strobe        = 1'b0;
		in_data          = 8'h00;
		invert_mirroring = 1'b0;

		add_row(0, 8'h01, 1'b0, 128'h4E45531A_01014120_00000000_00000000);   // Clean, mapper 0x24
		add_row(1, 8'h01, 1'b1, 128'h4E45531A_02001230_00000000_4469736B);   // Dirty, CHR RAM
		add_row(2, 8'h01, 1'b1, 128'h4E45531A_00030918_25000700_00000019);   // NES 2.0 with piano
		add_row(3, `CHEAT_FILE_TYPE, 1'b1, 128'h01000000_34120000_00000000_63000000);
		add_row(4, 8'h01, 1'b0, 128'h4E45541A_01010000_00000000_00000000);   // Bad magic
		add_row(5, 8'h01, 1'b0, 128'h4E45531A_01010400_00000000_00000000);   // Trainer

		repeat (16) @(posedge clk);
		#1 reset_nes = 1'b0;
		@(negedge clk);
		check_bit("mem_write", mem_write, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("error", error, 1'b0);
		check_bit("cheat_valid", cheat_valid, 1'b0);
		@(posedge clk);
		#1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].ftype == `CHEAT_FILE_TYPE) begin
				run_cheat_row(rows[i], last_rom);
			end else begin
				run_rom_row(rows[i]);
				last_rom = rows[i];
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- hw/nes_download_top.sv
// Cartridge download top level
// Splits host bytes between the ROM loader and the cheat packer

`timescale 1ns/1ps
`include "nes_loader_consts.svh"

module nes_download_top (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    downloading,
	input  logic [7:0]              file_type,
	input  logic                    in_strobe,
	input  logic [7:0]              in_data,
	input  logic                    invert_mirroring,
	output logic [`MEM_ADDR_W-1:0]  mem_addr,
	output logic [7:0]              mem_data,
	output logic                    mem_write,
	output logic                    busy,
	output logic                    done,
	output logic                    error,
	output ines_pkg::mapper_flags_t mapper_flags,
	output cheat_pkg::cheat_code_t  cheat_code,
	output logic                    cheat_valid
);

	logic is_cheat;
	logic rom_downloading;
	logic rom_strobe;
	logic cheat_downloading;
	logic cheat_strobe;

	// File type routing
	assign is_cheat          = (file_type == `CHEAT_FILE_TYPE);
	assign rom_downloading   = downloading && !is_cheat;
	assign rom_strobe        = in_strobe && rom_downloading;
	assign cheat_downloading = downloading && is_cheat;
	assign cheat_strobe      = in_strobe && cheat_downloading;

	ines_header_if hdr_if ();

	rom_stream_loader loader_i (
		.clk             (clk),
		.reset_nes       (reset_nes),
		.rom_downloading (rom_downloading),
		.rom_strobe      (rom_strobe),
		.in_data         (in_data),
		.hdr             (hdr_if),
		.mem_addr        (mem_addr),
		.mem_data        (mem_data),
		.mem_write       (mem_write),
		.busy            (busy),
		.done            (done),
		.error           (error)
	);

	ines_header_decoder decoder_i (
		.invert_mirroring (invert_mirroring),
		.hdr              (hdr_if)
	);

	assign mapper_flags = hdr_if.flags;   // Held header bytes keep this stable

	cheat_code_packer packer_i (
		.clk               (clk),
		.reset_nes         (reset_nes),
		.cheat_downloading (cheat_downloading),
		.cheat_strobe      (cheat_strobe),
		.in_data           (in_data),
		.cheat_code        (cheat_code),
		.cheat_valid       (cheat_valid)
	);

endmodule

//--- hw/cheat_code_packer.sv
// Cheat file packer
// Gathers 16 cheat bytes into one code and pulses valid once

`timescale 1ns/1ps

module cheat_code_packer (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  cheat_downloading,
	input  logic                  cheat_strobe,
	input  logic [7:0]            in_data,
	output cheat_pkg::cheat_code_t cheat_code,
	output logic                  cheat_valid
);

	logic [3:0] byte_cnt;
	logic [6:0] lane;

	// Field k/4 counted from the top, byte k%4 from the bottom of the field
	assign lane = {~byte_cnt[3:2], byte_cnt[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_cnt    <= 4'd0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_downloading && cheat_strobe && (byte_cnt == 4'd15);
			if (!cheat_downloading)
				byte_cnt <= 4'd0;
			else if (cheat_strobe)
				byte_cnt <= byte_cnt + 4'd1;   // Wraps after the last byte
		end
	end

	always_ff @(posedge clk) begin
		if (cheat_downloading && cheat_strobe)
			cheat_code[lane +: 8] <= in_data;
	end

	// Every byte lane is filled before the code is announced
	a_code_complete: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |-> !$isunknown(cheat_code));

endmodule

//--- hw/rom_stream_loader.sv
// iNES ROM loader
// Captures the header, then streams PRG and CHR bytes into memory

`timescale 1ns/1ps
`include "nes_loader_consts.svh"

module rom_stream_loader (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   rom_downloading,
	input  logic                   rom_strobe,
	input  logic [7:0]             in_data,
	ines_header_if.store           hdr,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	output logic [7:0]             mem_data,
	output logic                   mem_write,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);

	ines_pkg::loader_state_e state;

	logic [3:0]             hdr_cnt;
	logic [`MEM_ADDR_W-1:0] bytes_left;
	logic                   dl_q;
	logic                   start;
	logic                   hdr_wr;
	logic [3:0]             hdr_idx;

	assign start   = rom_downloading && !dl_q;   // New image begins
	assign hdr_wr  = rom_strobe && (start || state == ines_pkg::HEADER);
	assign hdr_idx = start ? 4'd0 : hdr_cnt;

	// Payload passes straight through on an accepted strobe
	assign mem_data  = in_data;
	assign mem_write = rom_strobe && !start && (bytes_left != '0) &&
	                   (state == ines_pkg::PRG || state == ines_pkg::CHR);

	always_ff @(posedge clk) begin
		if (hdr_wr)
			hdr.header[hdr_idx] <= in_data;
	end

	//////////////////////////////////////////////////////////////////////////////
	// Load sequencing
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ines_pkg::HEADER;
			hdr_cnt    <= 4'd0;
			bytes_left <= '0;
			mem_addr   <= '0;
			dl_q       <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			dl_q <= rom_downloading;
			if (start) begin
				state   <= ines_pkg::HEADER;
				hdr_cnt <= {3'd0, rom_strobe};   // First byte may arrive with the edge
				busy    <= 1'b0;
				done    <= 1'b0;
				error   <= 1'b0;
			end else begin
				case (state)
				ines_pkg::HEADER:
					if (rom_strobe) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'(`INES_HEADER_BYTES - 1)) begin
							busy <= 1'b1;
							// Bytes 0..6 are already held, decoder results are settled
							if (hdr.magic_ok && !hdr.trainer) begin
								state      <= ines_pkg::PRG;
								mem_addr   <= '0;
								bytes_left <= `MEM_ADDR_W'(hdr.prg_pages) << `PRG_PAGE_SHIFT;
							end else begin
								state <= ines_pkg::ERROR;
							end
						end
					end
				ines_pkg::PRG, ines_pkg::CHR:
					if (bytes_left != '0) begin
						if (rom_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							mem_addr   <= mem_addr + 1'b1;
						end
					end else if (state == ines_pkg::PRG) begin
						state      <= ines_pkg::CHR;
						mem_addr   <= `CHR_BASE_ADDR;
						bytes_left <= `MEM_ADDR_W'(hdr.chr_pages) << `CHR_PAGE_SHIFT;
					end else begin
						state <= ines_pkg::DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				ines_pkg::ERROR: begin
					busy  <= 1'b0;
					done  <= 1'b1;
					error <= 1'b1;
				end
				default: ;   // DONE holds until the next image
				endcase
			end
		end
	end

	// Writes only while the payload phases keep the loader busy
	a_write_in_payload: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> (busy && !done));

	a_done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy));

endmodule

//--- hw/ines_header_decoder.sv
// iNES / NES 2.0 header decoder
// Magic check, page counts and the mapper flags word, all combinational

`timescale 1ns/1ps
`include "nes_loader_consts.svh"

module ines_header_decoder (
	input  logic invert_mirroring,
	ines_header_if.decode hdr
);

	logic       is_nes20;
	logic       is_dirty;
	logic [7:0] mapper;

	// Smallest n with pages <= 2^n, capped at 7
	function automatic logic [2:0] size_class(input logic [7:0] pages);
		logic [2:0] cls;
		cls = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if ({1'b0, pages} <= (9'd1 << n))
				cls = n[2:0];
		end
		return cls;
	endfunction

	assign hdr.magic_ok  = (hdr.header[0] == `INES_MAGIC0) && (hdr.header[1] == `INES_MAGIC1) &&
	                       (hdr.header[2] == `INES_MAGIC2) && (hdr.header[3] == `INES_MAGIC3);
	assign hdr.trainer   = hdr.header[6][2];
	assign hdr.prg_pages = hdr.header[4];
	assign hdr.chr_pages = hdr.header[5];   // 0 means CHR RAM

	assign is_nes20 = (hdr.header[7][3:2] == 2'b10);

	// Old dumps often carry junk such as "DiskDude!" in bytes 7..15
	assign is_dirty = !is_nes20 && ((hdr.header[9][7:1] != 7'd0) || (|hdr.header[15:10]));

	assign mapper = {is_dirty ? 4'h0 : hdr.header[7][7:4], hdr.header[6][7:4]};

	always_comb begin
		hdr.flags                = '0;
		hdr.flags.mapper         = mapper;
		hdr.flags.prg_size       = size_class(hdr.header[4]);
		hdr.flags.chr_size       = size_class(hdr.header[5]);
		hdr.flags.mirroring      = hdr.header[6][0] ^ invert_mirroring;
		hdr.flags.has_chr_ram    = (hdr.header[5] == 8'd0);
		hdr.flags.four_screen    = hdr.header[6][3];
		hdr.flags.has_saves      = hdr.header[6][1];

		// NES 2.0 extensions
		if (is_nes20) begin
			hdr.flags.submapper_byte = hdr.header[8];
			hdr.flags.prg_ram_shift  = hdr.header[10][3:0];
			hdr.flags.piano          = (hdr.header[15][5:0] == 6'h19);   // Expansion device id
		end
	end

endmodule

//--- hw/ines_header_if.sv
// Header bundle between the ROM loader and the header decoder
// Raw header bytes one way, decoded facts the other

`timescale 1ns/1ps
`include "nes_loader_consts.svh"

interface ines_header_if;

	logic [`INES_HEADER_BYTES-1:0][7:0] header;   // Byte 0 in the low slot

	logic                  magic_ok;
	logic                  trainer;
	logic [7:0]            prg_pages;
	logic [7:0]            chr_pages;
	ines_pkg::mapper_flags_t flags;

	// Loader side
	modport store (output header, input magic_ok, trainer, prg_pages, chr_pages, flags);

	// Decoder side
	modport decode (input header, output magic_ok, trainer, prg_pages, chr_pages, flags);

endinterface

//--- hw/cheat_pkg.sv
// Cheat code types
// One packed cheat entry as handed to the cheat engine

package cheat_pkg;

	// Fields in download order, flags first
	// Each field is little endian within its 32 bits
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

//--- hw/ines_pkg.sv
// ROM image types
// Loader state encoding and the decoded mapper flags word

package ines_pkg;

	// Loader progress through an iNES image
	typedef enum logic [2:0] {
		HEADER = 3'd0,   // Capturing the 16 header bytes
		PRG    = 3'd1,   // Streaming PRG ROM from address 0
		CHR    = 3'd2,   // Streaming CHR ROM from the CHR base
		ERROR  = 3'd3,   // Bad magic or trainer present
		DONE   = 3'd4
	} loader_state_e;

	// Mapper flags as seen by the console core
	// Layout is fixed, the mapper logic slices it by bit position
	typedef struct packed {
		logic       spare;
		logic       piano;            // Miracle piano attached
		logic [3:0] prg_ram_shift;    // NES 2.0 PRG RAM size, 64 << n
		logic       has_saves;        // Battery backed RAM
		logic [7:0] submapper_byte;   // NES 2.0 byte 8
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;        // 1 = vertical
		logic [2:0] chr_size;         // Power of two class of 8 KiB pages
		logic [2:0] prg_size;         // Power of two class of 16 KiB pages
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

//--- hw/nes_loader_consts.svh
// Constants for cartridge download handling
// iNES header layout, page sizes, memory map and the cheat file type

`ifndef NES_LOADER_CONSTS_SVH
`define NES_LOADER_CONSTS_SVH

//////////////////////////////////////////////////////////////////////////////
// iNES header
//////////////////////////////////////////////////////////////////////////////

`define INES_HEADER_BYTES 16

// "NES" followed by MS-DOS end of file
`define INES_MAGIC0 8'h4E
`define INES_MAGIC1 8'h45
`define INES_MAGIC2 8'h53
`define INES_MAGIC3 8'h1A

`define PRG_PAGE_SHIFT 14       // 16 KiB PRG pages
`define CHR_PAGE_SHIFT 13       // 8 KiB CHR pages

//////////////////////////////////////////////////////////////////////////////
// Memory map and host file types
//////////////////////////////////////////////////////////////////////////////

`define MEM_ADDR_W 22
`define CHR_BASE_ADDR 22'h200000    // CHR lives in the upper half

`define CHEAT_FILE_TYPE 8'hFF

`endif
